// ==== lenet_front.f ====
+incdir+design
design/lenet_pkg.sv
design/line_buffer.sv
design/coef_regs.sv
design/frame_ctrl.sv
design/conv_unit.sv
design/pool_unit.sv
design/lenet_front.sv
sim/lenet_front_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the lenet front testbench with verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal -f lenet_front.f --top-module lenet_front_tb \
	-o lenet_front_sim > build.log 2>&1 \
	&& ./obj_dir/lenet_front_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2> /dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q '^\*\*\* PASSED \*\*\*$' sim.log && echo "simulation ok" \
	|| { echo "simulation failed"; exit 1; }

// ==== sim/lenet_front_tb.sv ====
`timescale 1ns/100ps

`include "lenet_cfg.svh"

module lenet_front_tb;

	localparam int NM = `LENET_MAPS;
	localparam int NPM = `LENET_COEFS_PER_MAP;
	localparam int K = `LENET_KSIZE;
	localparam int IC = `LENET_IMG_COLS;
	localparam int IR = `LENET_IMG_ROWS;
	localparam int CC = IC - K + 1; // conv width
	localparam int CR = IR - K + 1;
	localparam int FEAT_TOP = (1 << (`LENET_FEAT_W - 1)) - 1; // clamp ceiling
	localparam int NT = 6;

	localparam int COEF_RESET = 0; // registers left as reset cleared them
	localparam int COEF_CENTRE = 1;
	localparam int COEF_RANDOM = 2;
	localparam int COEF_MAX = 3;
	localparam int IMG_RANDOM = 0;
	localparam int IMG_MAX = 1; // every pixel 127

	typedef struct {
		string name;
		int coef_mode;
		int img_mode;
		int gap_pct; // percent of idle input cycles
		int frames;
		int beats; // pooled beats the test must produce
	} test_t;

	typedef struct packed {
		logic [31:0] row;
		logic [31:0] col;
		logic [31:0] due; // cycle count at which the beat is sampled
		logic [NM-1:0][31:0] val;
	} beat_t;

	logic clk = 1'b0;
	logic rst_n;
	lenet_pkg::pixel_t pixel;
	logic pixel_valid;
	lenet_pkg::cfg_wr_t cfg;
	lenet_pkg::pool_beat_t pool_out;

	test_t tests [NT];
	int w [NM][NPM]; // model copy of the coefficients
	int img [IR][IC];
	int conv_ref [NM][CR][CC];
	beat_t exp_q [$]; // beats still owed by the DUT
	beat_t head;
	int cyc = 0;
	int errors = 0;
	int checks = 0;
	int beats_seen = 0;

	lenet_front dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.pixel(pixel),
		.pixel_valid(pixel_valid),
		.cfg(cfg),
		.pool_out(pool_out)
	);

	always #10 clk = ~clk; // 20 ns period

	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cyc);
		end
	endtask

	// C1 value for one map and conv position
	function automatic int conv_at(input int m, input int y, input int x);
		int acc;
		acc = w[m][NPM-1] * (1 << `LENET_BIAS_SHIFT);
		for (int i = 0; i < K; i++)
			for (int j = 0; j < K; j++)
				acc += w[m][i*K + j] * img[y+i][x+j]; // tap 0 is top left
		if (acc < 0)
			return 0;
		if (acc > FEAT_TOP)
			return FEAT_TOP;
		return acc;
	endfunction

	// S2 max over one 2x2 block
	function automatic int pool_at(input int m, input int py, input int px);
		int best;
		best = 0; // conv values never go below zero
		for (int dy = 0; dy < 2; dy++)
			for (int dx = 0; dx < 2; dx++)
				if (conv_ref[m][2*py+dy][2*px+dx] > best)
					best = conv_ref[m][2*py+dy][2*px+dx];
		return best;
	endfunction

	// output monitor on the falling edge
	always @(negedge clk) begin
		if (pool_out.valid === 1'b1) begin
			beats_seen++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("beat at row %0d col %0d came out with none expected",
					pool_out.row, pool_out.col);
			end else begin
				head = exp_q.pop_front();
				check_val("pool_out.row", 32'(pool_out.row), head.row);
				check_val("pool_out.col", 32'(pool_out.col), head.col);
				for (int m = 0; m < NM; m++)
					check_val($sformatf("pool_out.value[%0d]", m), 32'(pool_out.value[m]),
						head.val[m]);
				check_val("beat cycle", 32'(cyc), head.due);
			end
		end
	end

	task automatic load_coefs(input int mode);
		for (int m = 0; m < NM; m++) begin
			for (int k = 0; k < NPM; k++) begin
				case (mode)
					COEF_CENTRE: w[m][k] = (k == K*K/2) ? ((m == 0) ? 1 : -1) : 0;
					COEF_RANDOM: w[m][k] = int'($urandom_range(255)) - 128;
					COEF_MAX: w[m][k] = 127; // bias too
					default: w[m][k] = 0;
				endcase
			end
		end
		if (mode != COEF_RESET) begin
			for (int m = 0; m < NM; m++) begin
				for (int k = 0; k < NPM; k++) begin
					@(posedge clk);
					cfg <= '{we: 1'b1, addr: lenet_pkg::CFG_AW'(m*NPM + k),
						data: lenet_pkg::coef_t'(w[m][k])};
				end
			end
			@(posedge clk);
			cfg <= '0;
		end
	endtask

	// one frame in raster order with the pooled beats it completes queued
	task automatic send_frame(input int img_mode, input int gap);
		beat_t b;
		for (int r = 0; r < IR; r++)
			for (int c = 0; c < IC; c++)
				img[r][c] = (img_mode == IMG_MAX) ? 127 : int'($urandom_range(255)) - 128;
		for (int m = 0; m < NM; m++)
			for (int y = 0; y < CR; y++)
				for (int x = 0; x < CC; x++)
					conv_ref[m][y][x] = conv_at(m, y, x);
		for (int r = 0; r < IR; r++) begin
			for (int c = 0; c < IC; c++) begin
				while (gap > 0 && int'($urandom_range(99)) < gap) begin
					@(posedge clk);
					pixel_valid <= 1'b0; // idle cycle
				end
				@(posedge clk);
				pixel <= lenet_pkg::pixel_t'(img[r][c]);
				pixel_valid <= 1'b1;
				// pixel (2py+5, 2px+5) closes block (py, px)
				if (r >= K && c >= K && (r - K) % 2 == 0 && (c - K) % 2 == 0) begin
					b.row = 32'((r - K) / 2);
					b.col = 32'((c - K) / 2);
					b.due = 32'(cyc + 4); // accepted next edge and out two edges later
					for (int m = 0; m < NM; m++)
						b.val[m] = 32'(pool_at(m, int'(b.row), int'(b.col)));
					exp_q.push_back(b);
				end
			end
		end
	endtask

	initial begin
		longint wd_ns;
		int err0;
		int seen0;
		void'($urandom(79817));
		rst_n = 1'b0;
		pixel = '0;
		pixel_valid = 1'b0;
		cfg = '0;
		tests[0] = '{"reset and zero coefficients", COEF_RESET, IMG_RANDOM, 0, 1, 36};
		tests[1] = '{"single centre tap", COEF_CENTRE, IMG_RANDOM, 0, 1, 36};
		tests[2] = '{"random weights and pixels", COEF_RANDOM, IMG_RANDOM, 0, 1, 36};
		tests[3] = '{"saturation", COEF_MAX, IMG_MAX, 0, 1, 36};
		tests[4] = '{"random idle gaps", COEF_RANDOM, IMG_RANDOM, 40, 2, 72};
		tests[5] = '{"back to back frames", COEF_RANDOM, IMG_RANDOM, 0, 2, 72};
		wd_ns = 40000; // reset, coefficient writes and drain
		for (int t = 0; t < NT; t++)
			wd_ns += longint'(tests[t].frames) * IR * IC * (100 + tests[t].gap_pct) / 100 * 2 * 20;
		fork
			begin
				#(wd_ns);
				$display("timeout: run still busy after %0d ns", wd_ns);
				$display("*** FAILED ***");
				$finish;
			end
		join_none
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		for (int t = 0; t < NT; t++) begin
			err0 = errors;
			seen0 = beats_seen;
			load_coefs(tests[t].coef_mode);
			for (int f = 0; f < tests[t].frames; f++)
				send_frame(tests[t].img_mode, tests[t].gap_pct); // frames run back to back
			@(posedge clk);
			pixel_valid <= 1'b0;
			for (int i = 0; i < 16 && exp_q.size() != 0; i++)
				@(posedge clk); // bounded wait for the owed beats
			repeat (4) @(posedge clk); // catch stray beats
			if (beats_seen - seen0 != tests[t].beats) begin
				errors++;
				$display("test %0d produced %0d beats instead of %0d", t,
					beats_seen - seen0, tests[t].beats);
			end
			exp_q.delete(); // drop beats that never came
			$display("test %0d %s: %0d beats, %0d errors", t, tests[t].name,
				beats_seen - seen0, errors - err0);
		end
		$display("%0d tests, %0d checks, %0d errors", NT, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== design/lenet_front.sv ====
`timescale 1ns/100ps

`include "lenet_cfg.svh"

module lenet_front (
	input logic clk,
	input logic rst_n,
	input lenet_pkg::pixel_t pixel, // raster order greyscale
	input logic pixel_valid,
	input lenet_pkg::cfg_wr_t cfg, // coefficient writes
	output lenet_pkg::pool_beat_t pool_out
);

	logic shift;
	logic win_valid;
	logic [lenet_pkg::CONV_CW-1:0] win_row;
	logic [lenet_pkg::CONV_CW-1:0] win_col;
	lenet_pkg::pixel_t [3:0] rows; // four older image rows
	lenet_pkg::coef_set_t coefs;
	logic conv_valid;
	logic [lenet_pkg::CONV_CW-1:0] conv_row;
	logic [lenet_pkg::CONV_CW-1:0] conv_col;
	lenet_pkg::feat_vec_t conv_feat;

	// frame position and window detect
	frame_ctrl frame_ctrl_i (
		.clk(clk),
		.rst_n(rst_n),
		.pixel_valid(pixel_valid),
		.shift(shift),
		.win_valid(win_valid),
		.win_row(win_row),
		.win_col(win_col)
	);

	// input row delay for the 5x5 window
	line_buffer #(
		.T(lenet_pkg::pixel_t),
		.DEPTH(`LENET_IMG_COLS)
	) pix_buf_i (
		.clk(clk),
		.rst_n(rst_n),
		.en(shift),
		.din(pixel),
		.rows_out(rows)
	);

	coef_regs coef_regs_i (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg),
		.coefs(coefs)
	);

	// C1 conv with bias and relu
	conv_unit conv_unit_i (
		.clk(clk),
		.rst_n(rst_n),
		.shift(shift),
		.pixel(pixel),
		.rows(rows),
		.win_valid(win_valid),
		.win_row(win_row),
		.win_col(win_col),
		.coefs(coefs),
		.conv_valid(conv_valid),
		.conv_row(conv_row),
		.conv_col(conv_col),
		.conv_feat(conv_feat)
	);

	// S2 2x2 max pool
	pool_unit pool_unit_i (
		.clk(clk),
		.rst_n(rst_n),
		.conv_valid(conv_valid),
		.conv_row(conv_row),
		.conv_col(conv_col),
		.conv_feat(conv_feat),
		.pool_out(pool_out)
	);

endmodule

// ==== design/pool_unit.sv ====
`timescale 1ns/100ps

`include "lenet_cfg.svh"

module pool_unit (
	input logic clk,
	input logic rst_n,
	input logic conv_valid,
	input logic [lenet_pkg::CONV_CW-1:0] conv_row,
	input logic [lenet_pkg::CONV_CW-1:0] conv_col,
	input lenet_pkg::feat_vec_t conv_feat,
	output lenet_pkg::pool_beat_t pool_out
);

	lenet_pkg::feat_vec_t [3:0] fb_rows; // only [0] is used here
	lenet_pkg::feat_vec_t up_cur; // previous row same column
	lenet_pkg::feat_vec_t up_prev; // previous row previous column
	lenet_pkg::feat_vec_t cur_prev; // this row previous column
	lenet_pkg::feat_vec_t pool_max;
	logic pool_hit; // bottom right corner of a 2x2 block

	function automatic lenet_pkg::feat_t fmax(input lenet_pkg::feat_t a,
		input lenet_pkg::feat_t b);
		return (a > b) ? a : b;
	endfunction

	// one conv row of history
	line_buffer #(
		.T(lenet_pkg::feat_vec_t),
		.DEPTH(lenet_pkg::CONV_COLS)
	) row_buf_i (
		.clk(clk),
		.rst_n(rst_n),
		.en(conv_valid),
		.din(conv_feat),
		.rows_out(fb_rows)
	);

	assign up_cur = fb_rows[0];

	// column holds for both rows
	always_ff @(posedge clk) begin
		if (conv_valid) begin
			cur_prev <= conv_feat;
			up_prev <= up_cur;
		end
	end

	assign pool_hit = conv_valid && conv_row[0] && conv_col[0]; // odd row and odd col

	// per map max of the four neighbours
	always_comb begin
		for (int m = 0; m < `LENET_MAPS; m++)
			pool_max[m] = fmax(fmax(up_prev[m], up_cur[m]), fmax(cur_prev[m], conv_feat[m]));
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pool_out.valid <= 1'b0;
		end else begin
			pool_out.valid <= pool_hit; // strobe only
			if (pool_hit) begin
				// halve conv coordinates
				pool_out.row <= conv_row[lenet_pkg::CONV_CW-1:1];
				pool_out.col <= conv_col[lenet_pkg::CONV_CW-1:1];
				pool_out.value <= pool_max;
			end
		end
	end

endmodule

// ==== design/conv_unit.sv ====
`timescale 1ns/100ps

`include "lenet_cfg.svh"

module conv_unit (
	input logic clk,
	input logic rst_n,
	input logic shift, // accepted pixel this cycle
	input lenet_pkg::pixel_t pixel, // newest row
	input lenet_pkg::pixel_t [3:0] rows, // [0] one row back
	input logic win_valid,
	input logic [lenet_pkg::CONV_CW-1:0] win_row,
	input logic [lenet_pkg::CONV_CW-1:0] win_col,
	input lenet_pkg::coef_set_t coefs,
	output logic conv_valid,
	output logic [lenet_pkg::CONV_CW-1:0] conv_row,
	output logic [lenet_pkg::CONV_CW-1:0] conv_col,
	output lenet_pkg::feat_vec_t conv_feat
);

	localparam int K = `LENET_KSIZE;
	localparam int AW = `LENET_ACC_W;

	// window [row][col] with oldest row and column at 0
	lenet_pkg::pixel_t win [K][K];

	logic pend_valid; // window just completed
	logic [lenet_pkg::CONV_CW-1:0] pend_row;
	logic [lenet_pkg::CONV_CW-1:0] pend_col;

	logic signed [AW-1:0] acc [`LENET_MAPS];
	lenet_pkg::feat_vec_t feat_next;

	// slide left and load the new column
	always_ff @(posedge clk) begin
		if (shift) begin
			for (int r = 0; r < K; r++) begin
				for (int c = 0; c < K - 1; c++)
					win[r][c] <= win[r][c+1];
			end
			for (int r = 0; r < K - 1; r++)
				win[r][K-1] <= rows[K-2-r]; // top row from four rows back
			win[K-1][K-1] <= pixel;
		end
	end

	// mac over the window for each map
	always_comb begin
		for (int m = 0; m < `LENET_MAPS; m++) begin
			acc[m] = AW'($signed(coefs[m][K*K])) <<< `LENET_BIAS_SHIFT; // scaled bias
			for (int r = 0; r < K; r++) begin
				for (int c = 0; c < K; c++)
					acc[m] += $signed(win[r][c]) * $signed(coefs[m][r*K + c]);
			end
			// relu then clamp
			if (acc[m] < 0)
				feat_next[m] = '0;
			else if (acc[m] > lenet_pkg::FEAT_MAX)
				feat_next[m] = lenet_pkg::feat_t'(lenet_pkg::FEAT_MAX);
			else
				feat_next[m] = acc[m][`LENET_FEAT_W-1:0];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pend_valid <= 1'b0;
			conv_valid <= 1'b0;
		end else begin
			pend_valid <= win_valid;
			conv_valid <= pend_valid; // window settled one cycle earlier
		end
	end

	// coordinates and result ride the valid pipe
	always_ff @(posedge clk) begin
		if (win_valid) begin
			pend_row <= win_row;
			pend_col <= win_col;
		end
		if (pend_valid) begin
			conv_row <= pend_row;
			conv_col <= pend_col;
			conv_feat <= feat_next;
		end
	end

endmodule

// ==== design/frame_ctrl.sv ====
`timescale 1ns/100ps

`include "lenet_cfg.svh"

module frame_ctrl (
	input logic clk,
	input logic rst_n,
	input logic pixel_valid,
	output logic shift, // accept strobe for buffer and window
	output logic win_valid, // full 5x5 window ends at this pixel
	output logic [lenet_pkg::CONV_CW-1:0] win_row,
	output logic [lenet_pkg::CONV_CW-1:0] win_col
);

	localparam int CW = lenet_pkg::IMG_CW;
	localparam int K = `LENET_KSIZE;

	logic [CW-1:0] col; // column of the pixel now on the input
	logic [CW-1:0] row;
	logic last_col;
	logic last_row;

	assign last_col = (col == CW'(`LENET_IMG_COLS - 1));
	assign last_row = (row == CW'(`LENET_IMG_ROWS - 1));

	// raster counters advance only on accepted pixels
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col <= '0;
			row <= '0;
		end else if (pixel_valid) begin
			if (last_col) begin
				col <= '0;
				// frame wraps after the last row
				if (last_row)
					row <= '0;
				else
					row <= row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	assign shift = pixel_valid;

	// needs K-1 rows and columns already seen
	assign win_valid = pixel_valid && (row >= CW'(K - 1)) && (col >= CW'(K - 1));

	// window position in conv coordinates
	always_comb begin
		win_row = lenet_pkg::CONV_CW'(row - CW'(K - 1));
		win_col = lenet_pkg::CONV_CW'(col - CW'(K - 1));
	end

endmodule

// ==== design/coef_regs.sv ====
`timescale 1ns/100ps

`include "lenet_cfg.svh"

module coef_regs (
	input logic clk,
	input logic rst_n,
	input lenet_pkg::cfg_wr_t cfg, // write port
	output lenet_pkg::coef_set_t coefs // every weight and bias
);

	localparam int NPM = `LENET_COEFS_PER_MAP;
	localparam int NC = `LENET_MAPS * NPM;

	lenet_pkg::coef_t regs [NC]; // flat by config address
	logic addr_ok;

	// addresses past the last map are dropped
	assign addr_ok = (int'(cfg.addr) < NC);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NC; i++)
				regs[i] <= '0; // all zero until configured
		end else if (cfg.we && addr_ok) begin
			regs[cfg.addr] <= cfg.data;
		end
	end

	// unflatten into [map][index]
	always_comb begin
		for (int m = 0; m < `LENET_MAPS; m++) begin
			for (int k = 0; k < NPM; k++)
				coefs[m][k] = regs[m*NPM + k];
		end
	end

endmodule

// ==== design/line_buffer.sv ====
`timescale 1ns/100ps

module line_buffer #(
	parameter type T = logic [7:0], // payload type
	parameter int DEPTH = 16 // entries per row
) (
	input logic clk,
	input logic rst_n,
	input logic en, // advance by one entry
	input T din,
	output T [3:0] rows_out // [0] is one row back, [3] is four rows back
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// each word holds the four delayed rows of one column slot
	T [3:0] ram [DEPTH];
	logic [PW-1:0] ptr; // current column slot

	// old contents of the slot are the delayed rows
	assign rows_out = ram[ptr];

	// column pointer wraps every DEPTH entries
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr <= '0;
		end else if (en) begin
			if (ptr == PW'(DEPTH - 1))
				ptr <= '0;
			else
				ptr <= ptr + 1'b1;
		end
	end

	// push din in and move every row one step deeper
	always_ff @(posedge clk) begin
		if (en) begin
			ram[ptr][0] <= din;
			for (int r = 1; r < 4; r++)
				ram[ptr][r] <= ram[ptr][r-1];
		end
	end

endmodule

// ==== design/lenet_pkg.sv ====
package lenet_pkg;

`include "lenet_cfg.svh"

	// derived sizes
	localparam int CONV_COLS = `LENET_IMG_COLS - `LENET_KSIZE + 1; // 12
	localparam int CONV_ROWS = `LENET_IMG_ROWS - `LENET_KSIZE + 1;
	localparam int POOL_COLS = CONV_COLS / 2; // 6
	localparam int POOL_ROWS = CONV_ROWS / 2;
	localparam int N_COEFS = `LENET_MAPS * `LENET_COEFS_PER_MAP;

	// counter and address widths
	localparam int IMG_CW = $clog2(`LENET_IMG_COLS);
	localparam int CONV_CW = $clog2(CONV_COLS);
	localparam int POOL_CW = $clog2(POOL_COLS);
	localparam int CFG_AW = $clog2(N_COEFS); // 6 bits for 52 entries

	localparam int FEAT_MAX = 2 ** (`LENET_FEAT_W - 1) - 1; // clamp ceiling

	typedef logic signed [`LENET_PIX_W-1:0] pixel_t;
	typedef logic signed [`LENET_COEF_W-1:0] coef_t;
	typedef logic signed [`LENET_FEAT_W-1:0] feat_t; // never negative after relu

	// all weights and biases [map][index]
	typedef coef_t [`LENET_MAPS-1:0][`LENET_COEFS_PER_MAP-1:0] coef_set_t;

	// one feature per map
	typedef feat_t [`LENET_MAPS-1:0] feat_vec_t;

	// coefficient write port
	// addr is map*26 + index, index 25 is the bias
	typedef struct packed {
		logic we;
		logic [CFG_AW-1:0] addr;
		coef_t data;
	} cfg_wr_t;

	// pooled output beat
	typedef struct packed {
		logic valid; // one cycle strobe
		logic [POOL_CW-1:0] row;
		logic [POOL_CW-1:0] col;
		feat_vec_t value;
	} pool_beat_t;

endpackage

// ==== design/lenet_cfg.svh ====
`ifndef LENET_CFG_SVH
`define LENET_CFG_SVH

// input frame geometry
`define LENET_IMG_COLS 16 // pixels per row
`define LENET_IMG_ROWS 16 // rows per frame

// C1 layer shape
`define LENET_MAPS 2 // feature maps computed in parallel
`define LENET_KSIZE 5 // square kernel side

// datapath widths
`define LENET_PIX_W 8 // greyscale pixel
`define LENET_COEF_W 8 // weight and bias
`define LENET_ACC_W 32 // mac accumulator
`define LENET_FEAT_W 16 // feature after relu and clamp

// bias is scaled up before the add
`define LENET_BIAS_SHIFT 4

// 25 taps plus one bias per map
`define LENET_COEFS_PER_MAP 26

`endif
